//--- rtl/rvAlu.sv
//**********************************************************
// Combinational ALU. slt compares signed operands.
// Codes outside the five used ones return the sum.
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module rvAlu (
    input  wire  rvPkg::aluCtrl_t ctrl,
    input  wire  rvPkg::word_t    srcA,
    input  wire  rvPkg::word_t    srcB,
    output rvPkg::word_t          result,
    output logic                  zero
);

    logic lessThan;

    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (ctrl)
            rvPkg::aluSub: result = srcA - srcB;
            rvPkg::aluAnd: result = srcA & srcB; // bitwise
            rvPkg::aluOr:  result = srcA | srcB;
            rvPkg::aluSlt: result = {31'b0, lessThan};
            default:       result = srcA + srcB;
        endcase
    end

    assign zero = (result == '0); // used by beq only

endmodule

`default_nettype wire

//--- rtl/rvControlFsm.sv
//**********************************************************
// Instruction sequencing FSM with Moore control outputs.
// Holds in Fetch while rst is high. Unknown opcodes go
// straight back to Fetch after Decode.
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module rvControlFsm (
    input  wire                  clk,
    input  wire                  rst,
    input  wire  rvPkg::opcode_t opcode,
    output rvPkg::ctrlWord_t     ctrl
);

    typedef enum logic [3:0] {
        stFetch, stDecode, stMemAdr, stMemRead, stMemWB, stMemWrite,
        stExecuteR, stAluWB, stExecuteI, stJal, stBeq
    } state_t;

    state_t state;
    state_t nextState;

    always_ff @(posedge clk) begin
        if (rst) state <= stFetch;
        else     state <= nextState;
    end

    always_comb begin
        case (state)
            stFetch: nextState = stDecode;
            stDecode: begin
                case (opcode)
                    rvPkg::opLoad, rvPkg::opStore: nextState = stMemAdr;
                    rvPkg::opRType:  nextState = stExecuteR;
                    rvPkg::opIType:  nextState = stExecuteI;
                    rvPkg::opJal:    nextState = stJal;
                    rvPkg::opBranch: nextState = stBeq;
                    default:         nextState = stFetch;
                endcase
            end
            stMemAdr:   nextState = (opcode == rvPkg::opLoad) ? stMemRead : stMemWrite;
            stMemRead:  nextState = stMemWB;
            stExecuteR: nextState = stAluWB;
            stExecuteI: nextState = stAluWB;
            stJal:      nextState = stAluWB;
            default:    nextState = stFetch; // MemWB, MemWrite, AluWB, Beq
        endcase
    end

    always_comb begin
        ctrl            = '0;
        ctrl.resultSrc  = rvPkg::selAluOut;
        ctrl.aluSrcA    = rvPkg::selPc;
        ctrl.aluSrcB    = rvPkg::selWriteData;
        ctrl.aluOpClass = rvPkg::opClassAdd;
        case (state)
            stFetch: begin
                ctrl.irWrite   = 1'b1;
                ctrl.pcUpdate  = 1'b1;
                ctrl.resultSrc = rvPkg::selAluResult; // pc + 4 straight into pc
                ctrl.aluSrcB   = rvPkg::selFour;
            end
            stDecode: begin
                ctrl.aluSrcA = rvPkg::selOldPc; // branch or jump target
                ctrl.aluSrcB = rvPkg::selImm;
            end
            stMemAdr: begin
                ctrl.aluSrcA = rvPkg::selRegA;
                ctrl.aluSrcB = rvPkg::selImm;
            end
            stMemRead: ctrl.adrSrc = 1'b1;
            stMemWB: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = rvPkg::selData;
            end
            stMemWrite: begin
                ctrl.adrSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            stExecuteR: begin
                ctrl.aluSrcA    = rvPkg::selRegA;
                ctrl.aluOpClass = rvPkg::opClassFunct;
            end
            stAluWB: ctrl.regWrite = 1'b1;
            stExecuteI: begin
                ctrl.aluSrcA    = rvPkg::selRegA;
                ctrl.aluSrcB    = rvPkg::selImm;
                ctrl.aluOpClass = rvPkg::opClassFunct;
            end
            stJal: begin
                ctrl.pcUpdate = 1'b1;            // target held in aluOut
                ctrl.aluSrcA  = rvPkg::selOldPc; // link address for AluWB
                ctrl.aluSrcB  = rvPkg::selFour;
            end
            stBeq: begin
                ctrl.branch     = 1'b1;
                ctrl.aluSrcA    = rvPkg::selRegA;
                ctrl.aluOpClass = rvPkg::opClassSub;
            end
            default: ctrl.irWrite = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rvDatapath.sv
//**********************************************************
// Datapath of the multicycle core. Every holding register
// except pc and the instruction pair loads each cycle, so
// values pass one cycle late between FSM states.
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module rvDatapath #(
    parameter rvPkg::word_t resetPc = 32'h00400000
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire  rvPkg::ctrlWord_t   ctrl,
    input  wire  rvPkg::decodeOut_t  dec,
    input  wire  rvPkg::word_t       memRData,
    output rvPkg::word_t             instr,
    output rvPkg::word_t             memAddr,
    output rvPkg::word_t             memWData
);

    rvPkg::word_t pc;
    rvPkg::word_t oldPc;
    rvPkg::word_t regA;
    rvPkg::word_t writeData;
    rvPkg::word_t aluOut;
    rvPkg::word_t readData;
    rvPkg::word_t rd1;
    rvPkg::word_t rd2;
    rvPkg::word_t srcA;
    rvPkg::word_t srcB;
    rvPkg::word_t aluResult;
    rvPkg::word_t result;
    rvPkg::word_t immExt;
    logic         zero;
    logic         pcEn;

    assign pcEn     = ctrl.pcUpdate | (ctrl.branch & zero); // beq taken on equal
    assign memAddr  = ctrl.adrSrc ? result : pc;
    assign memWData = writeData;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= resetPc;
            oldPc     <= '0;
            instr     <= '0;
            regA      <= '0;
            writeData <= '0;
            aluOut    <= '0;
            readData  <= '0;
        end else begin
            if (pcEn) pc <= result;
            if (ctrl.irWrite) begin
                oldPc <= pc; // kept for branch target and link
                instr <= memRData;
            end
            regA      <= rd1;
            writeData <= rd2;
            aluOut    <= aluResult;
            readData  <= memRData;
        end
    end

    always_comb begin
        case (dec.immSel)
            rvPkg::immS: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rvPkg::immB: immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            rvPkg::immJ: immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:     immExt = {{20{instr[31]}}, instr[31:20]}; // I format
        endcase
    end

    always_comb begin
        case (ctrl.aluSrcA)
            rvPkg::selOldPc: srcA = oldPc;
            rvPkg::selRegA:  srcA = regA;
            default:         srcA = pc;
        endcase
        case (ctrl.aluSrcB)
            rvPkg::selImm:  srcB = immExt;
            rvPkg::selFour: srcB = 32'd4;
            default:        srcB = writeData;
        endcase
        case (ctrl.resultSrc)
            rvPkg::selData:      result = readData;
            rvPkg::selAluResult: result = aluResult; // pc + 4 in Fetch
            default:             result = aluOut;
        endcase
    end

    rvRegFile u_rvRegFile (
        .clk (clk),
        .rst (rst),
        .we  (ctrl.regWrite),
        .ra1 (instr[19:15]),
        .ra2 (instr[24:20]),
        .wa  (instr[11:7]),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    rvAlu u_rvAlu (
        .ctrl   (dec.aluCtrl),
        .srcA   (srcA),
        .srcB   (srcB),
        .result (aluResult),
        .zero   (zero)
    );

endmodule

`default_nettype wire

//--- rtl/rvInstrDecoder.sv
//**********************************************************
// ALU function and immediate format from the instruction.
// Only the funct3 codes of the kept instructions decode.
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module rvInstrDecoder (
    input  wire  rvPkg::ctrlWord_t ctrl,
    input  wire  rvPkg::word_t     instr,
    output rvPkg::decodeOut_t      dec
);

    logic [2:0] funct3;
    logic       funct7b5;
    logic       opcodeB5;

    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    assign opcodeB5 = instr[5]; // set for R-type, clear for I-type

    always_comb begin
        case (instr[6:0])
            rvPkg::opStore:  dec.immSel = rvPkg::immS;
            rvPkg::opBranch: dec.immSel = rvPkg::immB;
            rvPkg::opJal:    dec.immSel = rvPkg::immJ;
            default:         dec.immSel = rvPkg::immI; // load and I-type
        endcase
        case (ctrl.aluOpClass)
            rvPkg::opClassSub: dec.aluCtrl = rvPkg::aluSub;
            rvPkg::opClassFunct: begin
                case (funct3)
                    3'b000: begin
                        if (opcodeB5 && funct7b5) dec.aluCtrl = rvPkg::aluSub;
                        else                      dec.aluCtrl = rvPkg::aluAdd;
                    end
                    3'b010:  dec.aluCtrl = rvPkg::aluSlt;
                    3'b110:  dec.aluCtrl = rvPkg::aluOr;
                    3'b111:  dec.aluCtrl = rvPkg::aluAnd;
                    default: dec.aluCtrl = rvPkg::aluAdd;
                endcase
            end
            default: dec.aluCtrl = rvPkg::aluAdd; // pc + 4, targets, addresses
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rvMulticycle.sv
//**********************************************************
// Multicycle RV32I core with one unified memory port.
// memRData must follow memAddr in the same cycle; writes
// land on the rising edge while memWrite is high.
// fetch is high for every fetch cycle, also during reset.
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module rvMulticycle #(
    parameter rvPkg::word_t resetPc = 32'h00400000 // must be word aligned
) (
    input  wire                clk,
    input  wire                rst,
    input  wire  rvPkg::word_t memRData,
    output rvPkg::word_t       memAddr,
    output rvPkg::word_t       memWData,
    output logic               memWrite,
    output logic               fetch
);

    rvPkg::ctrlWord_t  ctrl;
    rvPkg::decodeOut_t dec;
    rvPkg::word_t      instr;
    rvPkg::opcode_t    opcode;

    assign opcode   = rvPkg::opcode_t'(instr[6:0]);
    assign memWrite = ctrl.memWrite;
    assign fetch    = ctrl.irWrite; // instruction register loads only in Fetch

    rvControlFsm u_rvControlFsm (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    rvInstrDecoder u_rvInstrDecoder (
        .ctrl  (ctrl),
        .instr (instr),
        .dec   (dec)
    );

    rvDatapath #(.resetPc(resetPc)) u_rvDatapath (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .dec      (dec),
        .memRData (memRData),
        .instr    (instr),
        .memAddr  (memAddr),
        .memWData (memWData)
    );

endmodule

`default_nettype wire

//--- rtl/rvPkg.sv
//**********************************************************
// Shared types and encodings for the RV32I multicycle core.
// Covers only lw, sw, add, sub, and, or, slt, addi, andi,
// ori, slti, beq and jal. Other opcodes are not decoded.
//**********************************************************
`default_nettype none

package rvPkg;

    typedef logic [31:0] word_t;    // data or address word
    typedef logic [4:0]  regAddr_t; // register index

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opRType  = 7'b0110011,
        opIType  = 7'b0010011,
        opJal    = 7'b1101111,
        opBranch = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluCtrl_t;

    typedef enum logic [1:0] {immI, immS, immB, immJ} immSel_t;
    typedef enum logic [1:0] {opClassAdd, opClassSub, opClassFunct} aluOpClass_t;
    typedef enum logic [1:0] {selPc, selOldPc, selRegA} srcASel_t;
    typedef enum logic [1:0] {selWriteData, selImm, selFour} srcBSel_t;
    typedef enum logic [1:0] {selAluOut, selData, selAluResult} resultSel_t;

    // Moore outputs of the sequencing FSM
    typedef struct packed {
        logic        pcUpdate;
        logic        branch;     // pc loads on zero flag
        logic        regWrite;
        logic        memWrite;
        logic        irWrite;    // also the fetch strobe
        logic        adrSrc;     // 0 pc, 1 result
        resultSel_t  resultSrc;
        srcASel_t    aluSrcA;
        srcBSel_t    aluSrcB;
        aluOpClass_t aluOpClass;
    } ctrlWord_t;

    typedef struct packed {
        aluCtrl_t aluCtrl;
        immSel_t  immSel;
    } decodeOut_t;

endpackage

`default_nettype wire

//--- rtl/rvRegFile.sv
//**********************************************************
// 32 x 32 register bank, two async reads, one sync write.
// x0 reads as zero whatever was written to it.
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module rvRegFile (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  we,
    input  wire  rvPkg::regAddr_t ra1,
    input  wire  rvPkg::regAddr_t ra2,
    input  wire  rvPkg::regAddr_t wa,
    input  wire  rvPkg::word_t    wd,
    output rvPkg::word_t          rd1,
    output rvPkg::word_t          rd2
);

    rvPkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

//--- sim.f
rtl/rvPkg.sv
rtl/rvAlu.sv
rtl/rvRegFile.sv
rtl/rvInstrDecoder.sv
rtl/rvControlFsm.sv
rtl/rvDatapath.sv
rtl/rvMulticycle.sv
sim/rvMulticycle_chk.sv
sim/rvMonitor.sv
sim/tbRvMulticycle.sv

//--- sim/program.hex
// one instruction word per line, first word at 32'h00400000
40000093 // addi x1, x0, 1024
001080B3 // add  x1, x1, x1
001080B3 // add  x1, x1, x1
001080B3 // add  x1, x1, x1   x1 = 0x2000
0000A103 // lw   x2, 0(x1)
0040A183 // lw   x3, 4(x1)
00310233 // add  x4, x2, x3
403102B3 // sub  x5, x2, x3
00317333 // and  x6, x2, x3
003163B3 // or   x7, x2, x3
00312433 // slt  x8, x2, x3
FFB10493 // addi x9, x2, -5
0F017513 // andi x10, x2, 0x0f0
5551E593 // ori  x11, x3, 0x555
00012613 // slti x12, x2, 0
0240A023 // sw   x4, 32(x1)
0250A223 // sw   x5, 36(x1)
0260A423 // sw   x6, 40(x1)
0270A623 // sw   x7, 44(x1)
0280A823 // sw   x8, 48(x1)
0290AA23 // sw   x9, 52(x1)
02A0AC23 // sw   x10, 56(x1)
02B0AE23 // sw   x11, 60(x1)
04C0A023 // sw   x12, 64(x1)
00710013 // addi x0, x2, 7
0400A223 // sw   x0, 68(x1)
00100463 // beq  x0, x1, +8   not taken
00000463 // beq  x0, x0, +8   taken
0420A423 // sw   x2, 72(x1)   skipped
008006EF // jal  x13, +8
0430A623 // sw   x3, 76(x1)   skipped
04D0A823 // sw   x13, 80(x1)
0000006F // jal  x0, 0        end of program

//--- sim/rvMonitor.sv
//************************************************************
// Instruction-set model of the kept RV32I subset and the
// comparing process. Memory image must be preloaded before
// rst falls. Unknown opcodes step pc by four.
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module rvMonitor #(
    parameter rvPkg::word_t resetPc = 32'h00400000
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               fetch,
    input  wire               memWrite,
    input  wire rvPkg::word_t memAddr,
    input  wire rvPkg::word_t memWData,
    output logic              done,
    output int                checkCount,
    output int                errorCount
);

    localparam int fetchTimeout = 20; // cycles

    rvPkg::word_t image [rvPkg::word_t];
    rvPkg::word_t regs [32];
    rvPkg::word_t pc;

    task automatic preload(input rvPkg::word_t addr, input rvPkg::word_t data);
        image[addr] = data;
    endtask

    task automatic checkWord(input string name, input rvPkg::word_t expected,
                             input rvPkg::word_t actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("error %s expected %h got %h", name, expected, actual);
        end else begin
            $display("ok %s %h", name, actual);
        end
    endtask

    function automatic rvPkg::word_t aluOp(rvPkg::word_t ir, rvPkg::word_t a, rvPkg::word_t b);
        case (ir[14:12])
            3'b000:  return (ir[5] && ir[30]) ? a - b : a + b; // sub only for R-type
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    // one instruction at pc, returns fetch to fetch cycles
    function automatic int execute(output logic isStore, output rvPkg::word_t stAddr,
                                   output rvPkg::word_t stData);
        rvPkg::word_t ir;
        rvPkg::word_t a;
        rvPkg::word_t b;
        rvPkg::word_t immI;
        rvPkg::word_t res;
        rvPkg::word_t nextPc;
        logic         wr;
        int           lat;
        ir      = image.exists(pc) ? image[pc] : 32'h0;
        a       = regs[ir[19:15]];
        b       = regs[ir[24:20]];
        immI    = {{20{ir[31]}}, ir[31:20]};
        res     = pc + 4; // jal link
        nextPc  = pc + 4;
        wr      = 1'b1;
        isStore = 1'b0;
        stAddr  = '0;
        stData  = '0;
        lat     = 4;
        case (ir[6:0])
            7'b0000011: begin
                res = image[a + immI];
                lat = 5;
            end
            7'b0100011: begin
                wr            = 1'b0;
                isStore       = 1'b1;
                stAddr        = a + {{20{ir[31]}}, ir[31:25], ir[11:7]};
                stData        = b;
                image[stAddr] = b;
            end
            7'b0110011: res = aluOp(ir, a, b);
            7'b0010011: res = aluOp(ir, a, immI);
            7'b1101111: nextPc = pc + {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            7'b1100011: begin
                wr  = 1'b0;
                lat = 3;
                if (a == b) nextPc = pc + {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            end
            default: begin
                wr  = 1'b0;
                lat = 2; // Fetch, Decode only
            end
        endcase
        if (wr && ir[11:7] != 5'd0) regs[ir[11:7]] = res;
        pc = nextPc;
        return lat;
    endfunction

    initial begin : compare
        logic         isStore;
        rvPkg::word_t stAddr;
        rvPkg::word_t stData;
        rvPkg::word_t prevPc;
        int           latency;
        int           cycles;
        int           writes;
        done       = 1'b0;
        checkCount = 0;
        errorCount = 0;
        pc         = resetPc;
        foreach (regs[i]) regs[i] = '0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while ((rst || !fetch) && cycles < fetchTimeout);
        if (rst || !fetch) begin
            $display("the first fetch never came after reset");
            errorCount++;
            done = 1'b1;
        end else begin
            checkWord("memAddr", pc, memAddr);
        end
        while (!done) begin
            prevPc  = pc;
            latency = execute(isStore, stAddr, stData);
            cycles  = 0;
            writes  = 0;
            do begin
                @(posedge clk);
                cycles++;
                if (memWrite) begin
                    writes++;
                    if (!isStore) begin
                        $display("unexpected memory write after the instruction at %h", prevPc);
                        errorCount++;
                    end else begin
                        checkWord("memAddr", stAddr, memAddr);
                        checkWord("memWData", stData, memWData);
                    end
                end
            end while (!fetch && cycles < fetchTimeout);
            if (!fetch) begin
                $display("the fetch never came after the instruction at %h", prevPc);
                errorCount++;
                done = 1'b1;
            end else begin
                if (isStore && writes == 0) begin
                    $display("the store of the instruction at %h never happened", prevPc);
                    errorCount++;
                end
                checkWord("fetchInterval", latency, cycles);
                checkWord("memAddr", pc, memAddr);
                done = (pc == prevPc); // program ends jumping to itself
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/rvMulticycle_chk.sv
//************************************************************
// Memory port assertions, bound into every rvMulticycle.
// Checks are disabled while rst is high.
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module rvMulticycleChk (
    input wire               clk,
    input wire               rst,
    input wire               memWrite,
    input wire               fetch,
    input wire rvPkg::word_t memAddr
);

    int assertFails = 0; // summed into the final result

    noWriteInFetch: assert property (@(posedge clk) disable iff (rst) !(fetch && memWrite))
        else begin
            assertFails++;
            $error("memWrite high in a fetch cycle");
        end

    alignedFetch: assert property (@(posedge clk) disable iff (rst)
        fetch |-> (memAddr[1:0] == 2'b00))
        else begin
            assertFails++;
            $error("fetch address %h not word aligned", memAddr);
        end

    singleCycleWrite: assert property (@(posedge clk) disable iff (rst) memWrite |=> !memWrite)
        else begin
            assertFails++;
            $error("memWrite high in two cycles in a row");
        end

endmodule

bind rvMulticycle rvMulticycleChk u_rvMulticycleChk (
    .clk      (clk),
    .rst      (rst),
    .memWrite (memWrite),
    .fetch    (fetch),
    .memAddr  (memAddr)
);

`default_nettype wire

//--- sim/tbRvMulticycle.sv
//************************************************************
// Testbench for rvMulticycle. Run from the project root, the
// program is read from sim/program.hex. Eight data words at
// 32'h00002000 come from an LCG with a fixed seed.
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module tbRvMulticycle;

    localparam rvPkg::word_t progBase    = 32'h00400000;
    localparam rvPkg::word_t dataBase    = 32'h00002000;
    localparam int           progMax     = 64; // words
    localparam int           doneTimeout = 2000; // cycles

    logic         clk;
    logic         rst;
    rvPkg::word_t memRData;
    rvPkg::word_t memAddr;
    rvPkg::word_t memWData;
    logic         memWrite;
    logic         fetch;
    logic         monDone;
    int           checkCount;
    int           errorCount;
    int           writeCount;

    rvPkg::word_t mem [rvPkg::word_t];
    rvPkg::word_t progWords [progMax];

    function automatic rvPkg::word_t nextRandom(rvPkg::word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic rvPkg::word_t readWord(rvPkg::word_t addr);
        if (mem.exists(addr)) return mem[addr];
        return ~addr; // unmapped space
    endfunction

    rvMulticycle #(.resetPc(progBase)) u_rvMulticycle (
        .clk      (clk),
        .rst      (rst),
        .memRData (memRData),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memWrite (memWrite),
        .fetch    (fetch)
    );

    rvMonitor #(.resetPc(progBase)) u_rvMonitor (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memWData   (memWData),
        .done       (monDone),
        .checkCount (checkCount),
        .errorCount (errorCount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(memAddr or writeCount) memRData = readWord(memAddr); // combinational read

    always @(posedge clk) begin : memWritePort
        rvPkg::word_t wrAddr;
        rvPkg::word_t wrData;
        if (memWrite) begin
            wrAddr = memAddr;
            wrData = memWData;
            #1;
            mem[wrAddr] = wrData;
            writeCount++;
        end
    end

    initial begin : mainFlow
        rvPkg::word_t seed;
        int           waited;
        int           assertFails;
        rst        = 1'b1;
        memRData   = '0;
        writeCount = 0;
        $readmemh("sim/program.hex", progWords);
        for (int i = 0; i < progMax; i++) begin
            if (!$isunknown(progWords[i])) begin
                mem[progBase + 4 * i] = progWords[i];
                u_rvMonitor.preload(progBase + 4 * i, progWords[i]);
            end
        end
        seed = 32'h08f8500c;
        for (int i = 0; i < 8; i++) begin
            seed = nextRandom(seed);
            mem[dataBase + 4 * i] = seed;
            u_rvMonitor.preload(dataBase + 4 * i, seed);
        end
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        waited = 0;
        while (!monDone && waited < doneTimeout) begin
            @(posedge clk);
            waited++;
        end
        assertFails = u_rvMulticycle.u_rvMulticycleChk.assertFails;
        if (!monDone) begin
            $display("the run did not finish within %0d cycles", doneTimeout);
            $display("Testbench failed");
        end else begin
            $display("checks %0d, errors %0d, assertion failures %0d",
                     checkCount, errorCount, assertFails);
            if (errorCount == 0 && assertFails == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire
